// ==== arcade_pkg.sv ====
package arcade_pkg;

	//////////////////////////////
	// game selection
	//////////////////////////////

	typedef logic [2:0] game_sel_t; // game enable code from the front panel

	localparam game_sel_t game_flick = 3'd0; // flick master
	localparam game_sel_t game_mora  = 3'd1; // mora
	localparam game_sel_t game_hol   = 3'd2; // high or low
	localparam game_sel_t game_rain  = 3'd3; // rainfall
	// codes 4 to 7 pick no game, nothing scores

	//////////////////////////////
	// console state
	//////////////////////////////

	// initial after reset, play for one round, over holds the result
	typedef enum logic [1:0] {
		st_initial = 2'd0, // title screen, score cleared
		st_play    = 2'd1, // round running
		st_over    = 2'd2  // final score shown
	} console_state_t;

	localparam int round_cnt_w = 10; // width of the round countdown

	typedef logic [round_cnt_w-1:0] round_cnt_t; // cycles left in a round

endpackage

// ==== score_pkg.sv ====
package score_pkg;

	//////////////////////////////
	// binary score
	//////////////////////////////

	localparam int score_w = 8; // bits of binary score

	typedef logic [score_w-1:0] score_t; // 0 to 255

	localparam score_t score_max = 8'd255; // saturation limit

	//////////////////////////////
	// bcd display digits
	//////////////////////////////

	localparam int bcd_digits = 3; // hundreds, tens, units
	localparam int bcd_w      = 4; // bits per decimal digit

	typedef logic [bcd_w-1:0] bcd_digit_t; // 0 to 9

	// double dabble scratch, bcd nibbles on top of the binary bits
	typedef logic [bcd_digits*bcd_w+score_w-1:0] bcd_work_t;

	// one shift per binary bit
	localparam int bcd_steps = score_w;

endpackage

// ==== point_if.sv ====
`timescale 1ns/10ps

interface point_if;

	arcade_pkg::game_sel_t      game_sel;    // selected mini-game
	logic                       flick_point; // flick master point strobe
	logic                       mora_point;  // mora point strobe
	logic                       hol_point;   // high or low point strobe
	logic                       rain_point;  // rainfall point strobe
	arcade_pkg::console_state_t state;       // console fsm state

	// top side, fed from pins and the console fsm
	modport src (
		output game_sel,
		output flick_point,
		output mora_point,
		output hol_point,
		output rain_point,
		output state
	);

	// score accumulator side
	modport sink (
		input game_sel,
		input flick_point,
		input mora_point,
		input hol_point,
		input rain_point,
		input state
	);

endinterface

// ==== game_fsm.sv ====
`timescale 1ns/10ps

module game_fsm #(
	parameter int round_len = 400 // play length in clock cycles
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,     // one cycle start strobe
	output arcade_pkg::console_state_t state,     // current console state
	output logic [9:0]                 round_left // time display, 0 outside play
);

	// countdown reload, first play cycle already counts
	localparam arcade_pkg::round_cnt_t round_load =
		arcade_pkg::round_cnt_t'(round_len - 1);

	arcade_pkg::console_state_t state_nxt; // next state
	arcade_pkg::round_cnt_t     round_cnt; // cycles left in play
	logic                       enter_play; // initial to play this edge

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_nxt = state; // hold by default
		case (state)
			arcade_pkg::st_initial: begin
				if (start) begin
					state_nxt = arcade_pkg::st_play; // round begins
				end
			end
			arcade_pkg::st_play: begin
				// start is ignored here, only the clock ends a round
				if (round_cnt == '0) begin
					state_nxt = arcade_pkg::st_over;
				end
			end
			arcade_pkg::st_over: begin
				if (start) begin
					state_nxt = arcade_pkg::st_initial; // back to title
				end
			end
			default: begin
				state_nxt = arcade_pkg::st_initial; // unused code recovers
			end
		endcase
	end

	assign enter_play = (state != arcade_pkg::st_play) && (state_nxt == arcade_pkg::st_play);

	//////////////////////////////
	// state and countdown regs
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= arcade_pkg::st_initial;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_cnt <= '0;
		end else if (enter_play) begin
			round_cnt <= round_load; // full round on entry
		end else if (state != arcade_pkg::st_play) begin
			round_cnt <= '0; // idle outside play
		end else if (round_cnt != '0) begin
			round_cnt <= round_cnt - 1'b1; // stops at zero
		end
	end

	// counter sits at zero in initial and over
	assign round_left = round_cnt;

endmodule

// ==== point_cal_main.sv ====
`timescale 1ns/10ps

module point_cal_main (
	input  logic            clk,
	input  logic            rst_n,
	point_if.sink           pts,  // game strobes, selector, console state
	output score_pkg::score_t score // binary score
);

	logic point;     // strobe of the selected game
	logic in_play;   // counting allowed
	logic at_max;    // score pinned at the limit
	logic score_inc; // add one point this edge

	//////////////////////////////
	// game strobe select
	//////////////////////////////

	always_comb begin
		case (pts.game_sel)
			arcade_pkg::game_flick: point = pts.flick_point;
			arcade_pkg::game_mora:  point = pts.mora_point;
			arcade_pkg::game_hol:   point = pts.hol_point;
			arcade_pkg::game_rain:  point = pts.rain_point;
			default:                point = 1'b0; // no game, no points
		endcase
	end

	assign in_play   = (pts.state == arcade_pkg::st_play);
	assign at_max    = (score == score_pkg::score_max);
	assign score_inc = point && in_play && !at_max; // saturate, never wrap

	//////////////////////////////
	// score register
	//////////////////////////////

	// one point per strobe, visible right after the sampling edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
		end else if (pts.state == arcade_pkg::st_initial) begin
			score <= '0; // fresh game on title screen
		end else if (score_inc) begin
			score <= score_pkg::score_t'(score + 1'b1);
		end
	end

	// over holds the final value since in_play is low there

endmodule

// ==== binary_converter.sv ====
`timescale 1ns/10ps

module binary_converter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  score_pkg::score_t     answer_in,   // binary score
	output score_pkg::bcd_digit_t answer_hund, // hundreds digit
	output score_pkg::bcd_digit_t answer_tens, // tens digit
	output score_pkg::bcd_digit_t answer_unit, // unit digit
	output logic                  digits_valid // one cycle per finished conversion
);

	// nibble positions inside the work register
	localparam int unit_lsb = score_pkg::score_w;
	localparam int tens_lsb = unit_lsb + score_pkg::bcd_w;
	localparam int hund_lsb = tens_lsb + score_pkg::bcd_w;
	localparam logic [3:0] last_step = 4'(score_pkg::bcd_steps);

	typedef enum logic {
		conv_idle = 1'b0, // waiting for a new score
		conv_busy = 1'b1  // shifting
	} conv_state_t;

	conv_state_t           conv_st;      // sequencer state
	logic [3:0]            bcd_step;     // shifts done so far
	score_pkg::score_t     answer_latch; // value being or last converted
	score_pkg::bcd_work_t  work;         // double dabble scratch
	score_pkg::bcd_work_t  work_adj;     // after add-3 correction
	score_pkg::bcd_work_t  work_shift;   // after the shift
	logic                  conv_start;   // new value to convert
	logic                  conv_done;    // last busy cycle

	// add 3 to a digit of 5 or more so the shift carries into the next one
	function automatic score_pkg::bcd_digit_t add3(input score_pkg::bcd_digit_t d);
		if (d >= 4'd5) begin
			return score_pkg::bcd_digit_t'(d + 4'd3);
		end
		return d;
	endfunction

	//////////////////////////////
	// one double dabble step
	//////////////////////////////

	always_comb begin
		work_adj = work;
		work_adj[unit_lsb +: score_pkg::bcd_w] = add3(work[unit_lsb +: score_pkg::bcd_w]);
		work_adj[tens_lsb +: score_pkg::bcd_w] = add3(work[tens_lsb +: score_pkg::bcd_w]);
		work_adj[hund_lsb +: score_pkg::bcd_w] = add3(work[hund_lsb +: score_pkg::bcd_w]);
	end

	assign work_shift = {work_adj[$bits(work_adj)-2:0], 1'b0}; // msb out, zero in
	assign conv_start = (conv_st == conv_idle) && (answer_latch != answer_in);
	assign conv_done  = (conv_st == conv_busy) && (bcd_step == last_step);

	//////////////////////////////
	// sequencer
	//////////////////////////////

	// a change mid conversion is caught on the next idle cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_st      <= conv_idle;
			bcd_step     <= '0;
			answer_latch <= '0; // matches the cleared score
		end else if (conv_start) begin
			conv_st      <= conv_busy;
			bcd_step     <= '0;
			answer_latch <= answer_in;
		end else if (conv_done) begin
			conv_st <= conv_idle;
		end else if (conv_st == conv_busy) begin
			bcd_step <= bcd_step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (conv_start) begin
			work <= score_pkg::bcd_work_t'(answer_in); // bcd part starts at 0
		end else if ((conv_st == conv_busy) && !conv_done) begin
			work <= work_shift;
		end
	end

	//////////////////////////////
	// digit outputs
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			answer_hund  <= '0;
			answer_tens  <= '0;
			answer_unit  <= '0;
			digits_valid <= 1'b0;
		end else begin
			digits_valid <= conv_done; // single cycle pulse
			if (conv_done) begin
				answer_hund <= work[hund_lsb +: score_pkg::bcd_w];
				answer_tens <= work[tens_lsb +: score_pkg::bcd_w];
				answer_unit <= work[unit_lsb +: score_pkg::bcd_w];
			end
		end
	end

endmodule

// ==== arcade_score_top.sv ====
`timescale 1ns/10ps

module arcade_score_top #(
	parameter int round_len = 400 // play length in clock cycles
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,       // start button strobe
	input  arcade_pkg::game_sel_t      game_sel,    // active mini-game
	input  logic                       flick_point, // flick master point
	input  logic                       mora_point,  // mora point
	input  logic                       hol_point,   // high or low point
	input  logic                       rain_point,  // rainfall point
	output arcade_pkg::console_state_t state,       // console state
	output logic [9:0]                 round_left,  // time display
	output score_pkg::score_t          score,       // binary score to the other board
	output score_pkg::bcd_digit_t      digit_hund,  // hundreds digit
	output score_pkg::bcd_digit_t      digit_tens,  // tens digit
	output score_pkg::bcd_digit_t      digit_unit,  // unit digit
	output logic                       digits_valid // new digits strobe
);

	point_if pts_bus (); // strobes and state toward the accumulator

	//////////////////////////////
	// console fsm
	//////////////////////////////

	game_fsm #(
		.round_len (round_len)
	) u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.state      (state),
		.round_left (round_left)
	);

	// pins onto the bus
	assign pts_bus.game_sel    = game_sel;
	assign pts_bus.flick_point = flick_point;
	assign pts_bus.mora_point  = mora_point;
	assign pts_bus.hol_point   = hol_point;
	assign pts_bus.rain_point  = rain_point;
	assign pts_bus.state       = state; // fsm output shared with the port

	//////////////////////////////
	// score path
	//////////////////////////////

	point_cal_main u_point (
		.clk   (clk),
		.rst_n (rst_n),
		.pts   (pts_bus.sink),
		.score (score)
	);

	binary_converter u_bcd (
		.clk          (clk),
		.rst_n        (rst_n),
		.answer_in    (score),
		.answer_hund  (digit_hund),
		.answer_tens  (digit_tens),
		.answer_unit  (digit_unit),
		.digits_valid (digits_valid)
	);

endmodule

// ==== arcade_score_assert.sv ====
`timescale 1ns/10ps

module arcade_score_assert (
	input logic                       clk,
	input logic                       rst_n,
	input arcade_pkg::console_state_t state,
	input score_pkg::score_t          score,
	input logic                       digits_valid
);

	int fail_cnt = 0; // assertion failures so far

	//////////////////////////////
	// score rules
	//////////////////////////////

	// points only add up while a round runs
	score_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
		(state == arcade_pkg::st_play) |=> (score >= $past(score)))
		else begin
			$error("score dropped during play");
			fail_cnt++;
		end

	// title screen wipes the score
	score_clear: assert property (@(posedge clk) disable iff (!rst_n)
		(state == arcade_pkg::st_initial) |=> (score == '0))
		else begin
			$error("score not cleared in initial");
			fail_cnt++;
		end

	//////////////////////////////
	// strobes and state
	//////////////////////////////

	valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		digits_valid |=> !digits_valid)
		else begin
			$error("digits_valid high two cycles in a row");
			fail_cnt++;
		end

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {arcade_pkg::st_initial, arcade_pkg::st_play, arcade_pkg::st_over})
		else begin
			$error("state holds an unused code");
			fail_cnt++;
		end

endmodule

bind arcade_score_top arcade_score_assert u_score_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.state        (state),
	.score        (score),
	.digits_valid (digits_valid)
);

// ==== arcade_score_tb.sv ====
`timescale 1ns/10ps

module arcade_score_tb;

	localparam int round_len  = 300; // long enough to pass the 255 limit
	localparam int clk_period = 10;
	// six rounds plus idle stretches, half again as margin
	localparam int watchdog_cycles = (16 + 6 * round_len + 400) * 3 / 2;

	logic                       clk = 1'b0;
	logic                       rst_n;
	logic                       start;
	arcade_pkg::game_sel_t      game_sel;
	logic                       flick_point;
	logic                       mora_point;
	logic                       hol_point;
	logic                       rain_point;
	arcade_pkg::console_state_t state;
	logic [9:0]                 round_left;
	score_pkg::score_t          score;
	score_pkg::bcd_digit_t      digit_hund;
	score_pkg::bcd_digit_t      digit_tens;
	score_pkg::bcd_digit_t      digit_unit;
	logic                       digits_valid;

	arcade_pkg::console_state_t m_state;    // model console state
	int                         m_left;     // model round countdown
	score_pkg::score_t          m_score;    // model score
	logic                       pend_start; // inputs the dut samples next edge
	arcade_pkg::game_sel_t      pend_sel;
	logic [3:0]                 pend_pts;   // rain, hol, mora, flick
	logic [31:0]                lfsr = 32'd93999;
	int                         err_cnt = 0;
	int                         valid_cnt = 0; // digits_valid pulses seen
	int                         tests_ok = 0;
	int                         tests_bad = 0;

	always #(clk_period / 2) clk = ~clk;

	arcade_score_top #(.round_len(round_len)) u_arcade_score (.*);

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles, the run never finished", watchdog_cycles);
		$display("test failed");
		$finish;
	end

	always @(negedge clk) begin
		if (rst_n && digits_valid) begin
			valid_cnt++;
		end
	end

	//////////////////////////////
	// stimulus and model
	//////////////////////////////

	function automatic logic next_rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h80200003; // taps 32 22 2 1
		end
		return b;
	endfunction

	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[2:0], next_rand_bit()}; // one step per bit
		end
		return r;
	endfunction

	// one clock edge of the console as the rules describe it
	task automatic model_edge();
		logic pt;
		pt = (pend_sel < 3'd4) ? pend_pts[pend_sel[1:0]] : 1'b0; // 4..7 no game
		if (m_state == arcade_pkg::st_initial) begin
			m_score = '0;
		end else if (m_state == arcade_pkg::st_play && pt && m_score != score_pkg::score_max) begin
			m_score = score_pkg::score_t'(m_score + 1);
		end
		case (m_state)
			arcade_pkg::st_initial: begin
				if (pend_start) begin
					m_state = arcade_pkg::st_play;
					m_left  = round_len - 1;
				end
			end
			arcade_pkg::st_play: begin
				if (m_left == 0) begin
					m_state = arcade_pkg::st_over;
				end else begin
					m_left--;
				end
			end
			default: begin
				if (pend_start) begin
					m_state = arcade_pkg::st_initial; // start in over
				end
			end
		endcase
	endtask

	task automatic step(input logic s, input arcade_pkg::game_sel_t sel, input logic [3:0] pts);
		@(posedge clk);
		model_edge(); // edge that samples the previous inputs
		start       <= s;
		game_sel    <= sel;
		flick_point <= pts[0];
		mora_point  <= pts[1];
		hol_point   <= pts[2];
		rain_point  <= pts[3];
		pend_start = s;
		pend_sel   = sel;
		pend_pts   = pts;
		@(negedge clk);
		check_state(m_state);
		check_round_left(10'(m_left));
		check_score(m_score);
	endtask

	task automatic idle(input int n);
		repeat (n) step(1'b0, arcade_pkg::game_flick, 4'b0000);
	endtask

	task automatic start_round();
		step(1'b1, arcade_pkg::game_flick, 4'b0000);
		step(1'b0, arcade_pkg::game_flick, 4'b0000); // now in play
	endtask

	task automatic to_initial();
		while (m_state == arcade_pkg::st_play) begin
			step(1'b0, arcade_pkg::game_flick, 4'b0000);
		end
		if (m_state == arcade_pkg::st_over) begin
			step(1'b1, arcade_pkg::game_flick, 4'b0000);
			idle(2); // title screen, score cleared
		end
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_state(input arcade_pkg::console_state_t exp);
		if (state !== exp) begin
			$display("[ERROR] state: expected %h, got %h at %0t", exp, state, $time);
			err_cnt++;
		end
	endtask

	// time display, counts down in play and rests at zero elsewhere
	task automatic check_round_left(input logic [9:0] exp);
		if (round_left !== exp) begin
			$display("[ERROR] round_left: expected %h, got %h at %0t", exp, round_left, $time);
			err_cnt++;
		end
	endtask

	task automatic check_score(input score_pkg::score_t exp);
		if (score !== exp) begin
			$display("[ERROR] score: expected %h, got %h at %0t", exp, score, $time);
			err_cnt++;
		end
	endtask

	task automatic check_digits(input score_pkg::bcd_digit_t h, input score_pkg::bcd_digit_t t,
			input score_pkg::bcd_digit_t u);
		if ({digit_hund, digit_tens, digit_unit} !== {h, t, u}) begin
			$display("[ERROR] digit_hund/tens/unit: expected %h %h %h, got %h %h %h at %0t",
				h, t, u, digit_hund, digit_tens, digit_unit, $time);
			err_cnt++;
		end
	endtask

	task automatic check_model_digits();
		check_digits(score_pkg::bcd_digit_t'(m_score / 100),
			score_pkg::bcd_digit_t'((m_score / 10) % 10),
			score_pkg::bcd_digit_t'(m_score % 10));
	endtask

	task automatic end_test(input string name, input int err0);
		if (err_cnt == err0) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", name, err_cnt - err0);
			tests_bad++;
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_sequence();
		int err0;
		int play_cnt;
		err0 = err_cnt;
		check_state(arcade_pkg::st_initial);
		check_score('0);
		check_digits('0, '0, '0);
		if (digits_valid !== 1'b0) begin
			$display("digits_valid is high right after reset");
			err_cnt++;
		end
		idle(5);
		start_round();
		play_cnt = 1;
		for (int i = 0; i < 2 * round_len; i++) begin
			step(i == 50, arcade_pkg::game_flick, 4'b0000); // start mid round, ignored
			if (state == arcade_pkg::st_play) begin
				play_cnt++;
			end
		end
		if (play_cnt != round_len) begin
			$display("play lasted %0d cycles instead of %0d", play_cnt, round_len);
			err_cnt++;
		end
		to_initial();
		check_state(arcade_pkg::st_initial);
		end_test("sequence", err0);
	endtask

	task automatic test_play_only();
		int err0;
		err0 = err_cnt;
		repeat (20) step(1'b0, arcade_pkg::game_flick, 4'b1111); // title screen
		check_score('0);
		start_round();
		repeat (10) step(1'b0, arcade_pkg::game_mora, 4'b0010);
		while (m_state == arcade_pkg::st_play) begin
			step(1'b0, arcade_pkg::game_mora, 4'b0000);
		end
		repeat (20) step(1'b0, arcade_pkg::game_mora, 4'b1111); // over holds
		check_score(score_pkg::score_t'(10));
		to_initial();
		check_score('0);
		end_test("play_only", err0);
	endtask

	task automatic test_game_select();
		int err0;
		arcade_pkg::game_sel_t sel;
		err0 = err_cnt;
		start_round();
		for (int g = 0; g < 8; g++) begin
			repeat (25) step(1'b0, arcade_pkg::game_sel_t'(g), rand_bits(4));
		end
		for (int k = 0; k < 4; k++) begin
			sel = arcade_pkg::game_sel_t'(rand_bits(3)); // random game choice
			repeat (15) step(1'b0, sel, rand_bits(4));
		end
		to_initial();
		end_test("game_select", err0);
	endtask

	task automatic test_saturation();
		int err0;
		err0 = err_cnt;
		start_round();
		while (m_state == arcade_pkg::st_play) begin
			step(1'b0, arcade_pkg::game_rain, 4'b1111); // a point every cycle
		end
		check_score(score_pkg::score_max);
		idle(20);
		check_digits(4'd2, 4'd5, 4'd5);
		to_initial();
		end_test("saturation", err0);
	endtask

	task automatic test_bcd();
		int err0;
		int v0;
		int targets[5] = '{9, 10, 99, 100, 199};
		err0 = err_cnt;
		idle(20);
		check_model_digits(); // zero score
		start_round();
		foreach (targets[i]) begin
			v0 = valid_cnt;
			repeat (targets[i] - int'(m_score)) step(1'b0, arcade_pkg::game_flick, 4'b0001);
			idle(20); // converter settles within 18
			check_score(score_pkg::score_t'(targets[i]));
			check_model_digits();
			if (valid_cnt == v0) begin
				$display("no digits_valid pulse while converting %0d", targets[i]);
				err_cnt++;
			end
		end
		to_initial();
		end_test("bcd", err0);
	endtask

	initial begin
		rst_n       <= 1'b0;
		start       <= 1'b0;
		game_sel    <= arcade_pkg::game_flick;
		flick_point <= 1'b0;
		mora_point  <= 1'b0;
		hol_point   <= 1'b0;
		rain_point  <= 1'b0;
		m_state    = arcade_pkg::st_initial;
		m_left     = 0;
		m_score    = '0;
		pend_start = 1'b0;
		pend_sel   = arcade_pkg::game_flick;
		pend_pts   = 4'b0000;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		test_sequence();
		test_play_only();
		test_game_select();
		test_saturation();
		test_bcd();
		$display("summary: %0d ok, %0d failing, %0d errors, %0d assertion failures",
			tests_ok, tests_bad, err_cnt, u_arcade_score.u_score_assert.fail_cnt);
		if (err_cnt == 0 && u_arcade_score.u_score_assert.fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== arcade_score.f ====
arcade_pkg.sv
score_pkg.sv
point_if.sv
game_fsm.sv
point_cal_main.sv
binary_converter.sv
arcade_score_top.sv
arcade_score_assert.sv
arcade_score_tb.sv

// ==== Makefile ====
TOP = arcade_score_tb

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "test passed" sim.log

obj_dir/V$(TOP): arcade_score.f $(shell cat arcade_score.f)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f arcade_score.f

clean:
	rm -rf obj_dir sim.log
